//--- source/mipsIsaPkg.sv
package mipsIsaPkg;

	// ==================
	// major opcodes
	// ==================

	// only the opcodes the core decodes
	typedef enum logic [5:0] {
		opSpecial = 6'h00, // r-type, see funct
		opJ = 6'h02,
		opJal = 6'h03,
		opBeq = 6'h04,
		opBne = 6'h05,
		opAddiu = 6'h09,
		opOri = 6'h0d,
		opLui = 6'h0f,
		opLw = 6'h23,
		opSw = 6'h2b
	} opcode_t;

	// ==================
	// special functs
	// ==================

	// funct field, bits 5:0 of an r-type word
	typedef enum logic [5:0] {
		functSll = 6'h00, // all-zero word is sll r0 so it doubles as nop
		functJr = 6'h08,
		functAddu = 6'h21,
		functSubu = 6'h23,
		functAnd = 6'h24,
		functOr = 6'h25,
		functSlt = 6'h2a
	} funct_t;

	// ==================
	// alu operations
	// ==================

	// add is zero so a cleared pipe register decodes as add
	typedef enum logic [2:0] {
		aluAdd = 3'd0,
		aluSub = 3'd1,
		aluAnd = 3'd2,
		aluOr = 3'd3,
		aluSlt = 3'd4, // signed compare
		aluSll = 3'd5, // shift by shamt
		aluLui = 3'd6  // immediate into upper half
	} aluOp_t;

endpackage

//--- source/mipsCorePkg.sv
package mipsCorePkg;

	// ==================
	// machine types
	// ==================

	// data word, also pc and byte address
	typedef logic [31:0] word_t;

	// register number, also used for shamt
	typedef logic [4:0] regAddr_t;

	// jal writes its return address here
	localparam regAddr_t linkReg = 5'd31;

	// where an execute operand comes from
	typedef enum logic [1:0] {
		fwdReg = 2'b00,     // value read in decode
		fwdResultW = 2'b01, // writeback result
		fwdAluOutM = 2'b10  // alu result in memory
	} fwdSel_t;

endpackage

//--- source/alu.sv
`timescale 1ns/1ps

module alu (
	input mipsCorePkg::word_t a,
	input mipsCorePkg::word_t b,
	input mipsCorePkg::regAddr_t shamt,
	input mipsIsaPkg::aluOp_t aluOp,
	output mipsCorePkg::word_t y
);
	import mipsIsaPkg::*;

	// ==================
	// operation select
	// ==================
	always_comb begin
		case (aluOp)
			// addu/subu, no overflow trap
			aluAdd: y = a + b;
			aluSub: y = a - b;
			aluAnd: y = a & b;
			aluOr: y = a | b;
			// signed compare, result in bit 0
			aluSlt: y = {31'b0, $signed(a) < $signed(b)};
			// sll shifts rt, which arrives on b
			aluSll: y = b << shamt;
			// low half of immediate moves up
			aluLui: y = {b[15:0], 16'b0};
			default: y = '0;
		endcase
	end

endmodule

//--- source/regFile.sv
`timescale 1ns/1ps

module regFile (
	input logic clk,
	input logic rstN,
	input mipsCorePkg::regAddr_t rdAddrA,
	input mipsCorePkg::regAddr_t rdAddrB,
	output mipsCorePkg::word_t rdDataA,
	output mipsCorePkg::word_t rdDataB,
	input logic wrEn,
	input mipsCorePkg::regAddr_t wrAddr,
	input mipsCorePkg::word_t wrData
);
	import mipsCorePkg::*;

	word_t regs [32];

	// write on falling edge so decode reads the new value same cycle
	always_ff @(negedge clk or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end else if (wrEn && wrAddr != '0) begin
			regs[wrAddr] <= wrData;
		end
	end

	// r0 hardwired
	assign rdDataA = (rdAddrA == '0) ? '0 : regs[rdAddrA];
	assign rdDataB = (rdAddrB == '0) ? '0 : regs[rdAddrB];

	// writes aimed at r0 (nops included) leave it untouched
	assert property (@(negedge clk) disable iff (!rstN)
		(wrEn && wrAddr == '0) |=> $stable(regs[0]));

endmodule

//--- source/hazardUnit.sv
`timescale 1ns/1ps

module hazardUnit (
	input mipsCorePkg::regAddr_t rsD,
	input mipsCorePkg::regAddr_t rtD,
	input mipsCorePkg::regAddr_t rsE,
	input mipsCorePkg::regAddr_t rtE,
	input mipsCorePkg::regAddr_t writeRegE,
	input mipsCorePkg::regAddr_t writeRegM,
	input mipsCorePkg::regAddr_t writeRegW,
	input logic branchD,
	input logic jrD,
	input logic regWriteE,
	input logic memToRegE,
	input logic regWriteM,
	input logic memToRegM,
	input logic regWriteW,
	output logic forwardAD,
	output logic forwardBD,
	output mipsCorePkg::fwdSel_t forwardAE,
	output mipsCorePkg::fwdSel_t forwardBE,
	output logic stallF,
	output logic stallD,
	output logic flushE
);
	import mipsCorePkg::*;

	logic lwStall, branchStall;

	// decode compare takes memory alu result only
	assign forwardAD = (rsD != '0) && regWriteM && (writeRegM == rsD);
	assign forwardBD = (rtD != '0) && regWriteM && (writeRegM == rtD);

	// execute operands, memory wins over writeback
	always_comb begin
		forwardAE = fwdReg;
		forwardBE = fwdReg;
		if (rsE != '0 && regWriteM && writeRegM == rsE)
			forwardAE = fwdAluOutM;
		else if (rsE != '0 && regWriteW && writeRegW == rsE)
			forwardAE = fwdResultW;
		if (rtE != '0 && regWriteM && writeRegM == rtE)
			forwardBE = fwdAluOutM;
		else if (rtE != '0 && regWriteW && writeRegW == rtE)
			forwardBE = fwdResultW;
	end

	// load result not ready until writeback
	assign lwStall = memToRegE && (writeRegE != '0) && (writeRegE == rsD || writeRegE == rtD);

	// branch/jr in decode: wait on alu in execute or load in memory
	// jr looks at rs only
	assign branchStall = (branchD || jrD) && (
		(regWriteE && writeRegE != '0 && (writeRegE == rsD || (branchD && writeRegE == rtD))) ||
		(memToRegM && writeRegM != '0 && (writeRegM == rsD || (branchD && writeRegM == rtD))));

	always_comb begin
		stallD = lwStall || branchStall;
		stallF = stallD;
		flushE = stallD;
		// stall terms see a load by memToReg alone so a load must also write
		assert (!memToRegE || regWriteE);
		assert (!memToRegM || regWriteM);
	end

endmodule

//--- source/controlUnit.sv
`timescale 1ns/1ps

module controlUnit (
	input logic clk,
	input logic rstN,
	// decode
	input mipsIsaPkg::opcode_t opD,
	input mipsIsaPkg::funct_t functD,
	input logic flushE,
	output logic branchD,
	output logic branchNeD,
	output logic jumpD,
	output logic jalD,
	output logic jrD,
	// execute
	output mipsIsaPkg::aluOp_t aluOpE,
	output logic aluSrcE,
	output logic regDstE,
	output logic linkE,
	output logic memToRegE,
	output logic regWriteE,
	// memory and writeback
	output logic memToRegM,
	output logic regWriteM,
	output logic memWriteM,
	output logic memToRegW,
	output logic regWriteW
);
	import mipsIsaPkg::*;

	// controls decoded here, used later
	logic regWriteD, memToRegD, memWriteD;
	logic aluSrcD, regDstD;
	aluOp_t aluOpD;
	logic memWriteE;

	// ==================
	// main and alu decode
	// ==================
	always_comb begin
		{regWriteD, memToRegD, memWriteD, aluSrcD, regDstD} = '0;
		{branchD, branchNeD, jumpD, jalD, jrD} = '0;
		aluOpD = aluAdd;
		case (opD)
			opSpecial: begin
				regDstD = 1'b1;
				regWriteD = 1'b1;
				case (functD)
					functAddu: aluOpD = aluAdd;
					functSubu: aluOpD = aluSub;
					functAnd: aluOpD = aluAnd;
					functOr: aluOpD = aluOr;
					functSlt: aluOpD = aluSlt;
					functSll: aluOpD = aluSll;
					// jr only redirects, no write
					functJr: {regWriteD, jrD} = 2'b01;
					default: regWriteD = 1'b0;
				endcase
			end
			opAddiu: {aluSrcD, regWriteD} = 2'b11;
			opOri: begin
				{aluSrcD, regWriteD} = 2'b11;
				aluOpD = aluOr;
			end
			opLui: begin
				{aluSrcD, regWriteD} = 2'b11;
				aluOpD = aluLui;
			end
			opLw: {aluSrcD, regWriteD, memToRegD} = 3'b111;
			opSw: {aluSrcD, memWriteD} = 2'b11;
			opBeq: branchD = 1'b1;
			opBne: {branchD, branchNeD} = 2'b11;
			opJ: jumpD = 1'b1;
			// link value replaces the alu result in execute
			opJal: {jalD, regWriteD} = 2'b11;
			default: ;
		endcase
	end

	// decode to execute, bubble on flush
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			{aluSrcE, regDstE, linkE, memToRegE, regWriteE, memWriteE} <= '0;
			aluOpE <= aluAdd;
		end else if (flushE) begin
			{aluSrcE, regDstE, linkE, memToRegE, regWriteE, memWriteE} <= '0;
			aluOpE <= aluAdd;
		end else begin
			{aluSrcE, regDstE, linkE} <= {aluSrcD, regDstD, jalD};
			{memToRegE, regWriteE, memWriteE} <= {memToRegD, regWriteD, memWriteD};
			aluOpE <= aluOpD;
		end
	end

	// execute to memory to writeback
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			{memToRegM, regWriteM, memWriteM, memToRegW, regWriteW} <= '0;
		end else begin
			{memToRegM, regWriteM, memWriteM} <= {memToRegE, regWriteE, memWriteE};
			{memToRegW, regWriteW} <= {memToRegM, regWriteM};
		end
	end

	// a store never also claims a register write two stages on
	assert property (@(posedge clk) disable iff (!rstN) !(memWriteM && regWriteM));

endmodule

//--- source/datapath.sv
`timescale 1ns/1ps

module datapath #(
	parameter mipsCorePkg::word_t resetPc = '0
) (
	input logic clk,
	input logic rstN,
	// fetch port
	output mipsCorePkg::word_t instrAddr,
	input mipsCorePkg::word_t instr,
	// decode
	output mipsIsaPkg::opcode_t opD,
	output mipsIsaPkg::funct_t functD,
	input logic branchD,
	input logic branchNeD,
	input logic jumpD,
	input logic jalD,
	input logic jrD,
	// execute
	input mipsIsaPkg::aluOp_t aluOpE,
	input logic aluSrcE,
	input logic regDstE,
	input logic linkE,
	input logic memToRegE,
	input logic regWriteE,
	output logic flushE,
	// memory and data port
	input logic memToRegM,
	input logic regWriteM,
	input logic memWriteM,
	output mipsCorePkg::word_t dataAddr,
	output mipsCorePkg::word_t dataWrData,
	output logic dataWrEn,
	input mipsCorePkg::word_t dataRdData,
	// writeback
	input logic memToRegW,
	input logic regWriteW
);
	import mipsIsaPkg::*;
	import mipsCorePkg::*;

	word_t pcF, pcNextF, pcPlus4F;
	logic stallF, stallD;
	word_t instrD, pcPlus4D, pcPlus8D, immD, branchTargetD, jumpTargetD;
	word_t rdDataA, rdDataB, srcAD, srcBD;
	regAddr_t rsD, rtD, rdD, shamtD;
	logic forwardAD, forwardBD, takeBranchD;
	word_t srcAE, srcBE, immE, pcPlus8E, fwdAE, fwdBE, aluBE, aluYE, aluOutE;
	regAddr_t rsE, rtE, rdE, shamtE, writeRegE;
	fwdSel_t forwardAE, forwardBE;
	word_t aluOutM, writeDataM, aluOutW, readDataW, resultW;
	regAddr_t writeRegM, writeRegW;

	// ==================
	// fetch
	// ==================
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN)
			pcF <= resetPc;
		else if (!stallF)
			pcF <= pcNextF;
	end
	assign instrAddr = pcF;
	assign pcPlus4F = pcF + 32'd4;

	// fetch to decode, held on stall, never flushed (delay slot)
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN)
			{instrD, pcPlus4D} <= '0;
		else if (!stallD)
			{instrD, pcPlus4D} <= {instr, pcPlus4F};
	end

	// ==================
	// decode
	// ==================
	assign opD = opcode_t'(instrD[31:26]);
	assign functD = funct_t'(instrD[5:0]);
	assign {rsD, rtD, rdD, shamtD} = instrD[25:6];
	// ori zero extends, the rest sign extend
	assign immD = (opD == opOri) ? {16'b0, instrD[15:0]} : {{16{instrD[15]}}, instrD[15:0]};

	regFile i_regFile (
		.clk(clk), .rstN(rstN),
		.rdAddrA(rsD), .rdAddrB(rtD), .rdDataA(rdDataA), .rdDataB(rdDataB),
		.wrEn(regWriteW), .wrAddr(writeRegW), .wrData(resultW)
	);

	// early branch compare on forwarded operands
	assign srcAD = forwardAD ? aluOutM : rdDataA;
	assign srcBD = forwardBD ? aluOutM : rdDataB;
	assign takeBranchD = branchD && ((srcAD == srcBD) != branchNeD);
	assign branchTargetD = pcPlus4D + {immD[29:0], 2'b00};
	assign jumpTargetD = {pcPlus4D[31:28], instrD[25:0], 2'b00};
	// return address skips the delay slot
	assign pcPlus8D = pcPlus4D + 32'd4;

	// redirect lands after the delay slot already in fetch
	always_comb begin
		if (jrD)
			pcNextF = srcAD;
		else if (jumpD || jalD)
			pcNextF = jumpTargetD;
		else if (takeBranchD)
			pcNextF = branchTargetD;
		else
			pcNextF = pcPlus4F;
	end

	// decode to execute, bubble on flush
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			{srcAE, srcBE, immE, pcPlus8E, rsE, rtE, rdE, shamtE} <= '0;
		end else if (flushE) begin
			{srcAE, srcBE, immE, pcPlus8E, rsE, rtE, rdE, shamtE} <= '0;
		end else begin
			{srcAE, srcBE, immE, pcPlus8E} <= {rdDataA, rdDataB, immD, pcPlus8D};
			{rsE, rtE, rdE, shamtE} <= {rsD, rtD, rdD, shamtD};
		end
	end

	// ==================
	// execute
	// ==================
	always_comb begin
		case (forwardAE)
			fwdResultW: fwdAE = resultW;
			fwdAluOutM: fwdAE = aluOutM;
			default: fwdAE = srcAE;
		endcase
		case (forwardBE)
			fwdResultW: fwdBE = resultW;
			fwdAluOutM: fwdBE = aluOutM;
			default: fwdBE = srcBE;
		endcase
	end
	assign aluBE = aluSrcE ? immE : fwdBE;

	alu i_alu (.a(fwdAE), .b(aluBE), .shamt(shamtE), .aluOp(aluOpE), .y(aluYE));

	// jal forces r31 and pc+8 over the alu result
	assign writeRegE = linkE ? linkReg : (regDstE ? rdE : rtE);
	assign aluOutE = linkE ? pcPlus8E : aluYE;

	hazardUnit i_hazardUnit (.*);

	// ==================
	// memory, writeback
	// ==================
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			{aluOutM, writeDataM, writeRegM} <= '0;
			{aluOutW, readDataW, writeRegW} <= '0;
		end else begin
			{aluOutM, writeDataM, writeRegM} <= {aluOutE, fwdBE, writeRegE};
			{aluOutW, readDataW, writeRegW} <= {aluOutM, dataRdData, writeRegM};
		end
	end
	// single-cycle strobe straight from the memory stage
	assign dataAddr = aluOutM;
	assign dataWrData = writeDataM;
	assign dataWrEn = memWriteM;

	assign resultW = memToRegW ? readDataW : aluOutW;

	// store strobe must be clean once out of reset
	assert property (@(posedge clk) disable iff (!rstN) !$isunknown(dataWrEn));

endmodule

//--- source/mipsCore.sv
`timescale 1ns/1ps

module mipsCore #(
	parameter mipsCorePkg::word_t resetPc = '0
) (
	input logic clk,
	input logic rstN,
	// instruction fetch, read answers same cycle
	output mipsCorePkg::word_t instrAddr,
	input mipsCorePkg::word_t instr,
	// data port, write strobe only
	output mipsCorePkg::word_t dataAddr,
	output mipsCorePkg::word_t dataWrData,
	output logic dataWrEn,
	input mipsCorePkg::word_t dataRdData
);
	import mipsIsaPkg::*;

	// decode fields up, controls down
	opcode_t opD;
	funct_t functD;
	logic branchD, branchNeD, jumpD, jalD, jrD;
	aluOp_t aluOpE;
	logic aluSrcE, regDstE, linkE, memToRegE, regWriteE, flushE;
	logic memToRegM, regWriteM, memWriteM;
	logic memToRegW, regWriteW;

	// port names match across both blocks
	controlUnit i_controlUnit (.*);

	datapath #(.resetPc(resetPc)) i_datapath (.*);

endmodule

//--- bench/tbAsm.svh
`ifndef TB_ASM_SVH
`define TB_ASM_SVH

// ====================
// field packers
// ====================

// register numbers and immediates come in as int, cut to field width here
function automatic word_t rType(funct_t funct, int rs, int rt, int rd, int shamt);
	return {opSpecial, rs[4:0], rt[4:0], rd[4:0], shamt[4:0], funct};
endfunction

function automatic word_t iType(opcode_t op, int rs, int rt, int imm);
	return {op, rs[4:0], rt[4:0], imm[15:0]};
endfunction

// target is a byte address, word index kept
function automatic word_t jType(opcode_t op, int target);
	return {op, target[27:2]};
endfunction

// ====================
// r-type mnemonics
// ====================
function automatic word_t addu(int rd, int rs, int rt);
	return rType(functAddu, rs, rt, rd, 0);
endfunction

function automatic word_t subu(int rd, int rs, int rt);
	return rType(functSubu, rs, rt, rd, 0);
endfunction

function automatic word_t andReg(int rd, int rs, int rt);
	return rType(functAnd, rs, rt, rd, 0);
endfunction

function automatic word_t orReg(int rd, int rs, int rt);
	return rType(functOr, rs, rt, rd, 0);
endfunction

function automatic word_t slt(int rd, int rs, int rt);
	return rType(functSlt, rs, rt, rd, 0);
endfunction

// shifts rt, rs field stays zero
function automatic word_t sll(int rd, int rt, int shamt);
	return rType(functSll, 0, rt, rd, shamt);
endfunction

function automatic word_t jr(int rs);
	return rType(functJr, rs, 0, 0, 0);
endfunction

// all-zero word is sll r0, r0, 0
function automatic word_t nop();
	return 32'h0;
endfunction

// ====================
// i-type and j-type
// ====================
function automatic word_t addiu(int rt, int rs, int imm);
	return iType(opAddiu, rs, rt, imm);
endfunction

function automatic word_t ori(int rt, int rs, int imm);
	return iType(opOri, rs, rt, imm);
endfunction

function automatic word_t lui(int rt, int imm);
	return iType(opLui, 0, rt, imm);
endfunction

// operand order follows lw rt, offset(base)
function automatic word_t lw(int rt, int offset, int base);
	return iType(opLw, base, rt, offset);
endfunction

function automatic word_t sw(int rt, int offset, int base);
	return iType(opSw, base, rt, offset);
endfunction

// offset counts words from the delay slot
function automatic word_t beq(int rs, int rt, int offset);
	return iType(opBeq, rs, rt, offset);
endfunction

function automatic word_t bne(int rs, int rt, int offset);
	return iType(opBne, rs, rt, offset);
endfunction

function automatic word_t jump(int target);
	return jType(opJ, target);
endfunction

function automatic word_t jal(int target);
	return jType(opJal, target);
endfunction

`endif

//--- bench/mipsCoreTb.sv
`timescale 1ns/1ps

module mipsCoreTb;
	import mipsIsaPkg::*;
	import mipsCorePkg::*;

	`include "tbAsm.svh"

	localparam word_t resetPc = 32'h0040_0000;
	localparam int memWords = 256;
	localparam int timeoutCycles = 3000;
	// last word of data memory marks the end of a program
	localparam word_t sentinelAddr = 32'h3fc;

	logic clk;
	logic rstN;
	word_t instrAddr;
	word_t instr;
	word_t dataAddr;
	word_t dataWrData;
	logic dataWrEn;
	word_t dataRdData;

	word_t imem [memWords];
	word_t dmem [memWords];
	int asmIdx;
	logic sentinelSeen;
	integer seed;

	mipsCore #(.resetPc(resetPc)) i_dut (.*);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// ====================
	// memory models
	// ====================

	// both reads answer in the same cycle
	assign instr = imem[instrAddr[9:2]];
	assign dataRdData = dmem[dataAddr[9:2]];

	// strobe is steady mid-cycle, store lands there
	always @(negedge clk) begin
		if (!rstN) begin
			sentinelSeen = 1'b0;
		end else if (dataWrEn) begin
			dmem[dataAddr[9:2]] = dataWrData;
			if (dataAddr == sentinelAddr)
				sentinelSeen = 1'b1;
		end
	end

	// untouched words keep a value unique to their address
	function automatic word_t fillPattern(word_t addr);
		return 32'hc3a5_0000 ^ addr ^ {addr[15:0], addr[31:16]};
	endfunction

	// ====================
	// helpers
	// ====================
	task automatic checkEq(input string name, input word_t actual, input word_t want);
		if (actual !== want) begin
			$display("[FAIL] %s: got 0x%h, expected 0x%h", name, actual, want);
			$display("test failed");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic abortRun(input string why);
		$display("%s", why);
		$display("test failed");
		$fatal(1, "run aborted");
	endtask

	task automatic checkWord(input word_t addr, input word_t want);
		checkEq($sformatf("dmem[0x%h]", addr), dmem[addr[9:2]], want);
	endtask

	task automatic clearProgram();
		for (int i = 0; i < memWords; i++)
			imem[i] = nop();
		asmIdx = 0;
	endtask

	task automatic fillData();
		for (int i = 0; i < memWords; i++)
			dmem[i] = fillPattern(word_t'(i * 4));
	endtask

	task automatic emit(input word_t w);
		imem[asmIdx] = w;
		asmIdx++;
	endtask

	// sentinel store, then park on a jump to itself
	task automatic finishProgram();
		emit(sw(0, sentinelAddr, 0));
		emit(jump(resetPc + asmIdx * 4));
		emit(nop());
	endtask

	task automatic startReset();
		@(posedge clk);
		#1;
		rstN = 1'b0;
	endtask

	// ten cycles counted from startReset
	task automatic releaseReset();
		repeat (10) @(posedge clk);
		#1;
		rstN = 1'b1;
	endtask

	task automatic waitSentinel(input string testName);
		int cycles;
		cycles = 0;
		while (sentinelSeen !== 1'b1) begin
			if (cycles >= timeoutCycles)
				abortRun($sformatf("%s: no store to the sentinel address within %0d cycles",
					testName, timeoutCycles));
			@(posedge clk);
			cycles++;
		end
	endtask

	// ====================
	// directed tests
	// ====================
	task automatic testResetState();
		startReset();
		clearProgram();
		fillData();
		@(negedge clk);
		checkEq("instrAddr in reset", instrAddr, resetPc);
		checkEq("dataWrEn in reset", 32'(dataWrEn), 32'h0);
		releaseReset();
		// no rising edge yet since release
		@(negedge clk);
		checkEq("instrAddr after reset", instrAddr, resetPc);
		checkEq("dataWrEn after reset", 32'(dataWrEn), 32'h0);
	endtask

	task automatic testAluChain();
		logic [15:0] immA;
		logic [15:0] immB;
		logic [15:0] immC;
		word_t want [10];
		immA = 16'h8234;
		immB = 16'hc0f0;
		immC = 16'habcd;
		startReset();
		clearProgram();
		fillData();
		// most ops read the result just before it
		emit(addiu(1, 0, immA));
		emit(lui(3, immC));
		emit(ori(2, 3, immB));
		emit(addu(4, 3, 2));
		emit(subu(5, 4, 1));
		emit(andReg(6, 5, 2));
		emit(orReg(7, 6, 3));
		emit(slt(8, 7, 1));
		emit(sll(9, 4, 4));
		for (int r = 1; r <= 9; r++)
			emit(sw(r, 'h100 + 4 * r, 0));
		finishProgram();
		releaseReset();
		waitSentinel("alu chain");
		// addiu sign extends, ori zero extends
		want[1] = {{16{immA[15]}}, immA};
		want[3] = {immC, 16'h0};
		want[2] = want[3] | {16'h0, immB};
		want[4] = want[3] + want[2];
		want[5] = want[4] - want[1];
		want[6] = want[5] & want[2];
		want[7] = want[6] | want[3];
		want[8] = {31'b0, $signed(want[7]) < $signed(want[1])};
		want[9] = want[4] << 4;
		for (int r = 1; r <= 9; r++)
			checkWord(32'h100 + 4 * r, want[r]);
	endtask

	task automatic testLoadUse();
		word_t loaded;
		loaded = 32'h1357_9bdf;
		startReset();
		clearProgram();
		fillData();
		dmem[32'h80 >> 2] = loaded;
		emit(addiu(10, 0, 'h5a));
		emit(addiu(3, 0, 'h111));
		emit(lw(1, 'h80, 0));
		emit(addu(2, 1, 3));
		emit(sw(2, 'h104, 0));
		// loaded value straight into store data
		emit(lw(4, 'h80, 0));
		emit(sw(4, 'h108, 0));
		// branch needs a load, waits through execute and memory
		emit(lw(5, 'h80, 0));
		emit(beq(5, 4, 2));
		emit(sw(10, 'h10c, 0));
		emit(sw(10, 'h110, 0));
		emit(sw(5, 'h114, 0));
		finishProgram();
		releaseReset();
		waitSentinel("load use");
		checkWord(32'h104, loaded + 32'h111);
		checkWord(32'h108, loaded);
		checkWord(32'h10c, 32'h5a);
		checkWord(32'h110, fillPattern(32'h110));
		checkWord(32'h114, loaded);
	endtask

	task automatic testBranches();
		startReset();
		clearProgram();
		fillData();
		emit(addiu(1, 0, 1));
		emit(addiu(2, 0, 1));
		emit(addiu(3, 0, 2));
		emit(addiu(10, 0, 'h55));
		// beq taken: delay slot runs, next one skipped
		emit(beq(1, 2, 2));
		emit(sw(10, 'h200, 0));
		emit(sw(10, 'h204, 0));
		// beq not taken falls through
		emit(beq(1, 3, 2));
		emit(sw(10, 'h208, 0));
		emit(sw(10, 'h20c, 0));
		// bne taken
		emit(bne(1, 3, 2));
		emit(sw(10, 'h210, 0));
		emit(sw(10, 'h214, 0));
		// operand from the instruction right before
		emit(addiu(4, 0, 7));
		emit(bne(4, 0, 2));
		emit(sw(4, 'h218, 0));
		emit(sw(10, 'h21c, 0));
		emit(sw(10, 'h220, 0));
		finishProgram();
		releaseReset();
		waitSentinel("branches");
		checkWord(32'h200, 32'h55);
		checkWord(32'h204, fillPattern(32'h204));
		checkWord(32'h208, 32'h55);
		checkWord(32'h20c, 32'h55);
		checkWord(32'h210, 32'h55);
		checkWord(32'h214, fillPattern(32'h214));
		checkWord(32'h218, 32'h7);
		checkWord(32'h21c, fillPattern(32'h21c));
		checkWord(32'h220, 32'h55);
	endtask

	task automatic testJumps();
		word_t jalAddr;
		startReset();
		clearProgram();
		fillData();
		emit(addiu(10, 0, 'h66));
		emit(jump(resetPc + 16));
		emit(sw(10, 'h240, 0));
		emit(sw(10, 'h244, 0));
		// word 4, subroutine at word 10
		jalAddr = resetPc + asmIdx * 4;
		emit(jal(resetPc + 40));
		emit(sw(10, 'h248, 0));
		// return lands here
		emit(sw(31, 'h24c, 0));
		finishProgram();
		emit(addiu(11, 0, 'h77));
		emit(jr(31));
		emit(sw(11, 'h250, 0));
		emit(sw(10, 'h254, 0));
		releaseReset();
		waitSentinel("jumps");
		checkWord(32'h240, 32'h66);
		checkWord(32'h244, fillPattern(32'h244));
		checkWord(32'h248, 32'h66);
		// link skips the delay slot
		checkWord(32'h24c, jalAddr + 32'd8);
		checkWord(32'h250, 32'h77);
		checkWord(32'h254, fillPattern(32'h254));
	endtask

	task automatic testRandomOperands();
		word_t opA [10];
		word_t opB [10];
		seed = 32'hca7b_4ab8;
		startReset();
		clearProgram();
		fillData();
		for (int i = 0; i < 10; i++) begin
			opA[i] = $random(seed);
			opB[i] = $random(seed);
			dmem[(32'h100 + 8 * i) >> 2] = opA[i];
			dmem[(32'h104 + 8 * i) >> 2] = opB[i];
		end
		// second load feeds addu at once
		for (int i = 0; i < 10; i++) begin
			emit(lw(1, 'h100 + 8 * i, 0));
			emit(lw(2, 'h104 + 8 * i, 0));
			emit(addu(3, 1, 2));
			emit(subu(4, 1, 2));
			emit(slt(5, 1, 2));
			emit(sw(3, 'h200 + 12 * i, 0));
			emit(sw(4, 'h204 + 12 * i, 0));
			emit(sw(5, 'h208 + 12 * i, 0));
		end
		finishProgram();
		releaseReset();
		waitSentinel("random operands");
		for (int i = 0; i < 10; i++) begin
			checkWord(32'h200 + 12 * i, opA[i] + opB[i]);
			checkWord(32'h204 + 12 * i, opA[i] - opB[i]);
			checkWord(32'h208 + 12 * i, {31'b0, $signed(opA[i]) < $signed(opB[i])});
		end
	endtask

	// ====================
	// run
	// ====================
	initial begin
		rstN = 1'b0;
		clearProgram();
		fillData();
		testResetState();
		testAluChain();
		testLoadUse();
		testBranches();
		testJumps();
		testRandomOperands();
		$display("test passed");
		$finish;
	end

endmodule

//--- mipsCore.f
+incdir+bench
source/mipsIsaPkg.sv
source/mipsCorePkg.sv
source/alu.sv
source/regFile.sv
source/hazardUnit.sv
source/controlUnit.sv
source/datapath.sv
source/mipsCore.sv
bench/mipsCoreTb.sv

//--- Makefile
# Verilator simulation of the MIPS core testbench
# override any variable on the command line, e.g. make sim LOG=run.log

VERILATOR ?= verilator
TOP ?= mipsCoreTb
LOG ?= sim.log
FLIST ?= mipsCore.f

VFLAGS = --binary --timing --assert -Wno-fatal

.PHONY: sim clean

# build and run, then judge the run by its log
sim:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir obj_dir
	./obj_dir/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "test passed" $(LOG) || { echo "simulation did not pass, see $(LOG)"; exit 1; }

clean:
	rm -rf obj_dir $(LOG)
